//--- verilog.f
hw/soc_periph_pkg.sv
hw/periph_apb_decode.sv
hw/soc_ctrl_regs.sv
hw/ref_timer_unit.sv
hw/soc_event_gen.sv
hw/soc_periph_top.sv
dv/soc_periph_checker.sv
dv/soc_periph_assert.sv
dv/tb_soc_periph.sv

//--- Bender.yml
package:
  name: soc_periph

sources:
  # RTL, package first
  - hw/soc_periph_pkg.sv
  - hw/periph_apb_decode.sv
  - hw/soc_ctrl_regs.sv
  - hw/ref_timer_unit.sv
  - hw/soc_event_gen.sv
  - hw/soc_periph_top.sv
  # testbench
  - target: test
    files:
      - dv/soc_periph_checker.sv
      - dv/soc_periph_assert.sv
      - dv/tb_soc_periph.sv

//--- dv/tb_soc_periph.sv
/*
 * testbench for the peripheral subsystem
 * table driven APB traffic, event back-pressure, boot and fetch pins
 */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_periph;

  localparam logic [31:0] BOOT_DEF  = 32'h1A00_0080;
  localparam logic [31:0] ROM_BOOT  = 32'h1A00_0000;
  // window bases, only paddr[9:0] is decoded
  localparam logic [31:0] CTRL_BASE = 32'h1A10_4000;
  localparam logic [31:0] TMR_BASE  = 32'h1A10_4100;
  localparam logic [31:0] EVT_BASE  = 32'h1A10_4200;
  localparam logic [31:0] NONE_BASE = 32'h1A10_4300;
  localparam int unsigned APB_TIMEOUT = 16;

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_PINS, OP_OUT, OP_EVT, OP_DRAIN} op_e;

  // pins row data
  // [0] bootsel, [1] stoptimer, [2] fetch enable pulse, [3] its value
  // [5:4] ready mode, 0 random / 1 low / 2 high
  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
    logic        err;
  } row_t;

  logic                                  clk;
  logic                                  rst_n;
  logic                                  ref_clk;
  logic                                  stoptimer;
  logic                                  bootsel;
  logic                                  fetch_en_valid;
  logic                                  fetch_en;
  logic                                  evt_ready;
  logic [1:0]                            ready_mode;
  soc_periph_pkg::apb_req_t              apb_req;
  soc_periph_pkg::apb_rsp_t              apb_rsp;
  logic [31:0]                           bootaddr;
  logic                                  fetchen;
  logic                                  evt_valid;
  logic [soc_periph_pkg::EVNT_WIDTH-1:0] evt_data;
  logic                                  exp_rd;
  logic [31:0]                           exp_rdata;
  logic                                  exp_slverr;
  int                                    chk_errs;
  int                                    tb_errs;
  integer                                seed = 32'h255f5fe6;
  row_t                                  rows[$];

  soc_periph_top #(
    .BOOT_ADDR_DEFAULT (BOOT_DEF),
    .ROM_BOOT_ADDR     (ROM_BOOT)
  ) i_soc_periph_top (
    .clk_i               (clk),
    .rst_n_i             (rst_n),
    .ref_clk_i           (ref_clk),
    .apb_req_i           (apb_req),
    .apb_rsp_o           (apb_rsp),
    .stoptimer_i         (stoptimer),
    .bootsel_i           (bootsel),
    .fc_fetch_en_valid_i (fetch_en_valid),
    .fc_fetch_en_i       (fetch_en),
    .fc_bootaddr_o       (bootaddr),
    .fc_fetchen_o        (fetchen),
    .fc_event_valid_o    (evt_valid),
    .fc_event_data_o     (evt_data),
    .fc_event_ready_i    (evt_ready)
  );

  soc_periph_checker i_checker (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .apb_req_i    (apb_req),
    .apb_rsp_i    (apb_rsp),
    .evt_valid_i  (evt_valid),
    .evt_data_i   (evt_data),
    .evt_ready_i  (evt_ready),
    .bootaddr_i   (bootaddr),
    .fetchen_i    (fetchen),
    .exp_rd_i     (exp_rd),
    .exp_rdata_i  (exp_rdata),
    .exp_slverr_i (exp_slverr),
    .err_cnt_o    (chk_errs)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // consumer side of the event stream
  initial begin
    evt_ready = 1'b0;
    forever begin
      @(negedge clk);
      case (ready_mode)
        2'd0:    evt_ready = $random(seed) & 1;
        2'd1:    evt_ready = 1'b0;
        default: evt_ready = 1'b1;
      endcase
    end
  end

  function automatic void add(input op_e op, input logic [31:0] addr,
                              input logic [31:0] data, input logic [31:0] exp,
                              input logic err);
    rows.push_back(row_t'{op, addr, data, exp, err});
  endfunction

  function automatic void build_table();
    ////////////////////
    // boot address and fetch enable
    add(OP_RD,    CTRL_BASE + 32'h00, '0, BOOT_DEF, 1'b0);
    add(OP_RD,    CTRL_BASE + 32'h04, '0, '0, 1'b0);
    add(OP_OUT,   '0, BOOT_DEF, '0, 1'b0);
    add(OP_WR,    CTRL_BASE + 32'h00, 32'h1C00_8000, '0, 1'b0);
    add(OP_RD,    CTRL_BASE + 32'h00, '0, 32'h1C00_8000, 1'b0);
    add(OP_OUT,   '0, 32'h1C00_8000, '0, 1'b0);
    add(OP_PINS,  '0, 32'h01, '0, 1'b0);
    add(OP_OUT,   '0, ROM_BOOT, '0, 1'b0);
    add(OP_PINS,  '0, 32'h00, '0, 1'b0);
    add(OP_WR,    CTRL_BASE + 32'h04, 32'h1, '0, 1'b0);
    add(OP_RD,    CTRL_BASE + 32'h04, '0, 32'h1, 1'b0);
    add(OP_OUT,   '0, 32'h1C00_8000, 32'h1, 1'b0);
    // external override clears fetch enable
    add(OP_PINS,  '0, 32'h04, '0, 1'b0);
    add(OP_OUT,   '0, 32'h1C00_8000, '0, 1'b0);
    add(OP_RD,    CTRL_BASE + 32'h04, '0, '0, 1'b0);
    ////////////////////
    // map holes and unmapped offsets
    add(OP_RD,    NONE_BASE + 32'h00, '0, '0, 1'b1);
    add(OP_WR,    NONE_BASE + 32'h04, 32'hDEAD_BEEF, '0, 1'b1);
    add(OP_RD,    CTRL_BASE + 32'h10, '0, '0, 1'b1);
    add(OP_RD,    TMR_BASE + 32'h1C, '0, '0, 1'b1);
    add(OP_RD,    EVT_BASE + 32'h08, '0, '0, 1'b1);
    ////////////////////
    // software events, random ready, id from wdata[7:0]
    add(OP_EVT,   '0, 32'h3C, '0, 1'b0);
    add(OP_WR,    EVT_BASE + 32'h00, 32'h0000_1A3C, '0, 1'b0);
    add(OP_EVT,   '0, 32'hA5, '0, 1'b0);
    add(OP_WR,    EVT_BASE + 32'h00, 32'h0000_77A5, '0, 1'b0);
    add(OP_EVT,   '0, 32'h01, '0, 1'b0);
    add(OP_WR,    EVT_BASE + 32'h00, 32'h0000_0001, '0, 1'b0);
    add(OP_EVT,   '0, 32'hF0, '0, 1'b0);
    add(OP_WR,    EVT_BASE + 32'h00, 32'h0000_00F0, '0, 1'b0);
    add(OP_DRAIN, '0, 32'd200, '0, 1'b0);
    ////////////////////
    // five events into a blocked FIFO of four
    add(OP_PINS,  '0, 32'h10, '0, 1'b0);
    for (int i = 1; i <= 5; i++) begin
      add(OP_WR,  EVT_BASE + 32'h00, 32'h20 + i, '0, 1'b0);
    end
    add(OP_RD,    EVT_BASE + 32'h04, '0, 32'h104, 1'b0);
    add(OP_WR,    EVT_BASE + 32'h04, 32'h100, '0, 1'b0);
    add(OP_RD,    EVT_BASE + 32'h04, '0, 32'h004, 1'b0);
    for (int i = 1; i <= 4; i++) begin
      add(OP_EVT, '0, 32'h20 + i, '0, 1'b0);
    end
    add(OP_PINS,  '0, 32'h00, '0, 1'b0);
    add(OP_DRAIN, '0, 32'd200, '0, 1'b0);
    add(OP_RD,    EVT_BASE + 32'h04, '0, '0, 1'b0);
    ////////////////////
    // timer in clock mode, clear on match, compare 20
    add(OP_PINS,  '0, 32'h22, '0, 1'b0);
    add(OP_WR,    TMR_BASE + 32'h08, 32'd20, '0, 1'b0);
    add(OP_WR,    TMR_BASE + 32'h04, 32'd5, '0, 1'b0);
    add(OP_WR,    TMR_BASE + 32'h00, 32'h5, '0, 1'b0);
    // frozen by stoptimer
    add(OP_RD,    TMR_BASE + 32'h04, '0, 32'd5, 1'b0);
    add(OP_RD,    TMR_BASE + 32'h04, '0, 32'd5, 1'b0);
    add(OP_EVT,   '0, 32'h07, '0, 1'b0);
    add(OP_PINS,  '0, 32'h20, '0, 1'b0);
    add(OP_DRAIN, '0, 32'd100, '0, 1'b0);
    add(OP_PINS,  '0, 32'h22, '0, 1'b0);
    add(OP_WR,    TMR_BASE + 32'h00, 32'h0, '0, 1'b0);
  endfunction

  // setup phase, access phase, then wait for pready
  task automatic apb_xfer(input row_t r);
    int unsigned n;
    @(negedge clk);
    apb_req.paddr   = r.addr;
    apb_req.pwdata  = r.data;
    apb_req.pwrite  = (r.op == OP_WR);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    exp_rd          = (r.op == OP_RD);
    exp_rdata       = r.exp;
    exp_slverr      = r.err;
    @(negedge clk);
    apb_req.penable = 1'b1;
    n = 0;
    @(posedge clk);
    while (!apb_rsp.pready && n < APB_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (!apb_rsp.pready) begin
      $display("APB transfer to 0x%08h got no pready within %0d cycles", r.addr, APB_TIMEOUT);
      tb_errs++;
    end
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    exp_rd          = 1'b0;
  endtask

  task automatic set_pins(input logic [31:0] d);
    @(negedge clk);
    bootsel    = d[0];
    stoptimer  = d[1];
    ready_mode = d[5:4];
    if (d[2]) begin
      // one cycle override pulse
      fetch_en_valid = 1'b1;
      fetch_en       = d[3];
      @(negedge clk);
      fetch_en_valid = 1'b0;
    end
  endtask

  initial begin
    int total;
    rst_n          = 1'b0;
    ref_clk        = 1'b0;
    stoptimer      = 1'b0;
    bootsel        = 1'b0;
    fetch_en_valid = 1'b0;
    fetch_en       = 1'b0;
    ready_mode     = 2'd0;
    apb_req        = '0;
    exp_rd         = 1'b0;
    exp_rdata      = '0;
    exp_slverr     = 1'b0;
    tb_errs        = 0;
    build_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    foreach (rows[i]) begin
      case (rows[i].op)
        OP_WR, OP_RD: apb_xfer(rows[i]);
        OP_PINS:      set_pins(rows[i].data);
        OP_OUT:       i_checker.check_outputs(rows[i].data, rows[i].exp[0]);
        OP_EVT:       i_checker.expect_event(rows[i].data[7:0]);
        OP_DRAIN:     i_checker.wait_events(rows[i].data);
        default:      ;
      endcase
    end
    repeat (4) @(negedge clk);

    total = chk_errs + tb_errs + i_soc_periph_top.i_periph_assert.fail_cnt;
    $display("error count %0d (checker %0d, testbench %0d, assertions %0d)", total,
             chk_errs, tb_errs, i_soc_periph_top.i_periph_assert.fail_cnt);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/soc_periph_assert.sv
/*
 * protocol assertions for the peripheral subsystem, bound into the top level
 */
`timescale 1ns/1ps
`default_nettype none

module soc_periph_assert (
  input logic                                  clk_i,
  input logic                                  rst_n_i,
  input soc_periph_pkg::apb_req_t              apb_req_i,
  input soc_periph_pkg::apb_rsp_t              apb_rsp_i,
  input logic                                  fetch_en_valid_i,
  input logic                                  fetchen_i,
  input logic                                  evt_valid_i,
  input logic [soc_periph_pkg::EVNT_WIDTH-1:0] evt_data_i,
  input logic                                  evt_ready_i
);

  int   fail_cnt = 0;
  logic fetchen_wr;

  // completed bus write to FETCHEN
  assign fetchen_wr = apb_req_i.psel && apb_req_i.penable && apb_rsp_i.pready &&
                      apb_req_i.pwrite &&
                      (apb_req_i.paddr[9:8] == soc_periph_pkg::SEL_SOC_CTRL) &&
                      (apb_req_i.paddr[7:0] == soc_periph_pkg::REG_FETCHEN);

  // pready only in an access phase that directly follows its setup phase
  ready_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    apb_rsp_i.pready |-> apb_req_i.psel && apb_req_i.penable &&
                         $past(apb_req_i.psel && !apb_req_i.penable))
    else begin
      fail_cnt++;
      $error("pready outside an APB access phase");
    end

  // stalled event holds its id
  evt_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    evt_valid_i && !evt_ready_i |=> evt_valid_i && $stable(evt_data_i))
    else begin
      fail_cnt++;
      $error("event stream changed while stalled");
    end

  fetchen_cause: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(fetchen_i) |-> $past(fetch_en_valid_i || fetchen_wr))
    else begin
      fail_cnt++;
      $error("fetch enable rose without a write or override");
    end

endmodule

bind soc_periph_top soc_periph_assert i_periph_assert (
  .clk_i            (clk_i),
  .rst_n_i          (rst_n_i),
  .apb_req_i        (apb_req_i),
  .apb_rsp_i        (apb_rsp_o),
  .fetch_en_valid_i (fc_fetch_en_valid_i),
  .fetchen_i        (fc_fetchen_o),
  .evt_valid_i      (fc_event_valid_o),
  .evt_data_i       (fc_event_data_o),
  .evt_ready_i      (fc_event_ready_i)
);

`default_nettype wire

//--- dv/soc_periph_checker.sv
/*
 * scoreboard for the peripheral subsystem
 * APB read data and pslverr, the event stream, boot and fetch pins
 */
`timescale 1ns/1ps
`default_nettype none

module soc_periph_checker (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  soc_periph_pkg::apb_req_t              apb_req_i,
  input  soc_periph_pkg::apb_rsp_t              apb_rsp_i,
  input  logic                                  evt_valid_i,
  input  logic [soc_periph_pkg::EVNT_WIDTH-1:0] evt_data_i,
  input  logic                                  evt_ready_i,
  input  logic [31:0]                           bootaddr_i,
  input  logic                                  fetchen_i,
  input  logic                                  exp_rd_i,
  input  logic [31:0]                           exp_rdata_i,
  input  logic                                  exp_slverr_i,
  output int                                    err_cnt_o
);

  int                                    err_cnt = 0;
  // ids still owed by the event stream, oldest first
  logic [soc_periph_pkg::EVNT_WIDTH-1:0] exp_evt_q[$];
  logic [soc_periph_pkg::EVNT_WIDTH-1:0] exp_evt;

  assign err_cnt_o = err_cnt;

  task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("Mismatch at time %0t: %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
    err_cnt++;
  endtask

  ////////////////////
  // APB completion
  ////////////////////
  always @(posedge clk_i) begin
    if (rst_n_i && apb_req_i.psel && apb_req_i.penable && apb_rsp_i.pready) begin
      if (exp_rd_i && apb_rsp_i.prdata !== exp_rdata_i) begin
        mismatch("prdata", exp_rdata_i, apb_rsp_i.prdata);
      end
      if (apb_rsp_i.pslverr !== exp_slverr_i) begin
        mismatch("pslverr", 32'(exp_slverr_i), 32'(apb_rsp_i.pslverr));
      end
    end
  end

  ////////////////////
  // event stream
  ////////////////////
  always @(posedge clk_i) begin
    if (rst_n_i && evt_valid_i && evt_ready_i) begin
      if (exp_evt_q.size() == 0) begin
        $display("unexpected event 0x%02h transferred at time %0t", evt_data_i, $time);
        err_cnt++;
      end else begin
        exp_evt = exp_evt_q.pop_front();
        if (evt_data_i !== exp_evt) begin
          mismatch("fc_event_data_o", 32'(exp_evt), 32'(evt_data_i));
        end
      end
    end
  end

  task automatic expect_event(input logic [soc_periph_pkg::EVNT_WIDTH-1:0] id);
    exp_evt_q.push_back(id);
  endtask

  // queue is popped on rising edges, polled on falling ones
  task automatic wait_events(input int unsigned max_cycles);
    int unsigned n;
    n = 0;
    while (exp_evt_q.size() != 0 && n < max_cycles) begin
      @(negedge clk_i);
      n++;
    end
    if (exp_evt_q.size() != 0) begin
      $display("%0d expected event(s) did not arrive within %0d cycles", exp_evt_q.size(),
               max_cycles);
      err_cnt += exp_evt_q.size();
      exp_evt_q.delete();
    end
  endtask

  // pins as seen at the next rising edge
  task automatic check_outputs(input logic [31:0] exp_boot, input logic exp_fetch);
    @(posedge clk_i);
    if (bootaddr_i !== exp_boot) begin
      mismatch("fc_bootaddr_o", exp_boot, bootaddr_i);
    end
    if (fetchen_i !== exp_fetch) begin
      mismatch("fc_fetchen_o", 32'(exp_fetch), 32'(fetchen_i));
    end
  endtask

endmodule

`default_nettype wire

//--- hw/soc_periph_top.sv
/*
 * peripheral subsystem top level
 * APB decoder with SoC control, timer and event generator behind it
 */
`timescale 1ns/1ps
`default_nettype none

module soc_periph_top #(
  parameter logic [31:0] BOOT_ADDR_DEFAULT = 32'h1A00_0080,
  parameter logic [31:0] ROM_BOOT_ADDR     = 32'h1A00_0000
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  ref_clk_i,
  input  soc_periph_pkg::apb_req_t              apb_req_i,
  output soc_periph_pkg::apb_rsp_t              apb_rsp_o,
  input  logic                                  stoptimer_i,
  input  logic                                  bootsel_i,
  input  logic                                  fc_fetch_en_valid_i,
  input  logic                                  fc_fetch_en_i,
  output logic [31:0]                           fc_bootaddr_o,
  output logic                                  fc_fetchen_o,
  output logic                                  fc_event_valid_o,
  output logic [soc_periph_pkg::EVNT_WIDTH-1:0] fc_event_data_o,
  input  logic                                  fc_event_ready_i
);

  // per window register ports
  soc_periph_pkg::reg_req_t ctrl_req, tmr_req, evt_req;
  soc_periph_pkg::reg_rsp_t ctrl_rsp, tmr_rsp, evt_rsp;
  // timer compare pulse into the event FIFO
  logic                     tmr_match;

  ////////////////////
  // bus front end
  ////////////////////
  periph_apb_decode i_apb_decode (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .apb_req_i  (apb_req_i),
    .apb_rsp_o  (apb_rsp_o),
    .ctrl_req_o (ctrl_req),
    .tmr_req_o  (tmr_req),
    .evt_req_o  (evt_req),
    .ctrl_rsp_i (ctrl_rsp),
    .tmr_rsp_i  (tmr_rsp),
    .evt_rsp_i  (evt_rsp)
  );

  ////////////////////
  // peripherals
  ////////////////////
  soc_ctrl_regs #(
    .BOOT_ADDR_DEFAULT (BOOT_ADDR_DEFAULT),
    .ROM_BOOT_ADDR     (ROM_BOOT_ADDR)
  ) i_soc_ctrl (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .req_i               (ctrl_req),
    .rsp_o               (ctrl_rsp),
    .bootsel_i           (bootsel_i),
    .fc_fetch_en_valid_i (fc_fetch_en_valid_i),
    .fc_fetch_en_i       (fc_fetch_en_i),
    .fc_bootaddr_o       (fc_bootaddr_o),
    .fc_fetchen_o        (fc_fetchen_o)
  );

  ref_timer_unit i_timer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ref_clk_i   (ref_clk_i),
    .stoptimer_i (stoptimer_i),
    .req_i       (tmr_req),
    .rsp_o       (tmr_rsp),
    .tmr_match_o (tmr_match)
  );

  soc_event_gen i_event_gen (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .req_i            (evt_req),
    .rsp_o            (evt_rsp),
    .tmr_match_i      (tmr_match),
    .fc_event_valid_o (fc_event_valid_o),
    .fc_event_data_o  (fc_event_data_o),
    .fc_event_ready_i (fc_event_ready_i)
  );

endmodule

`default_nettype wire

//--- hw/soc_event_gen.sv
/*
 * event generator toward the fabric controller
 * software and timer sources into a 4 entry FIFO, valid/ready output stream
 */
`timescale 1ns/1ps
`default_nettype none

module soc_event_gen (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  soc_periph_pkg::reg_req_t              req_i,
  output soc_periph_pkg::reg_rsp_t              rsp_o,
  input  logic                                  tmr_match_i,
  output logic                                  fc_event_valid_o,
  output logic [soc_periph_pkg::EVNT_WIDTH-1:0] fc_event_data_o,
  input  logic                                  fc_event_ready_i
);

  localparam int unsigned EVT_FIFO_DEPTH = 4;
  localparam int unsigned PTR_W          = $clog2(EVT_FIFO_DEPTH);
  localparam int unsigned CNT_W          = $clog2(EVT_FIFO_DEPTH + 1);
  localparam int unsigned EW             = soc_periph_pkg::EVNT_WIDTH;

  logic [EW-1:0]    mem_q [EVT_FIFO_DEPTH];
  logic [PTR_W-1:0] wptr_q;
  logic [PTR_W-1:0] rptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             ovf_q;
  logic             tmr_pend_q;
  logic             sw_push;
  logic             tmr_push;
  logic             push;
  logic [EW-1:0]    push_data;
  logic             full;
  logic             do_push;
  logic             do_pop;

  ////////////////////
  // event sources
  ////////////////////
  assign sw_push = req_i.wr && (req_i.offs == soc_periph_pkg::REG_EVT_SW);

  // software first, a colliding timer event waits one cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tmr_pend_q <= 1'b0;
    end else begin
      tmr_pend_q <= sw_push & (tmr_match_i | tmr_pend_q);
    end
  end

  assign tmr_push  = ~sw_push & (tmr_match_i | tmr_pend_q);
  assign push      = sw_push | tmr_push;
  assign push_data = sw_push ? req_i.wdata[EW-1:0] : soc_periph_pkg::TIMER_EVENT_ID;

  ////////////////////
  // event FIFO
  ////////////////////
  assign full    = (cnt_q == CNT_W'(EVT_FIFO_DEPTH));
  // pushes into a full FIFO are lost
  assign do_push = push & ~full;
  assign do_pop  = fc_event_valid_o & fc_event_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (do_push) wptr_q <= wptr_q + 1'b1;
      if (do_pop)  rptr_q <= rptr_q + 1'b1;
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wptr_q] <= push_data;
  end

  // sticky overflow, a new drop wins over the clear
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ovf_q <= 1'b0;
    end else if (push && full) begin
      ovf_q <= 1'b1;
    end else if (req_i.wr && (req_i.offs == soc_periph_pkg::REG_EVT_STATUS) &&
                 req_i.wdata[8]) begin
      ovf_q <= 1'b0;
    end
  end

  // status read, sw event register reads as zero
  always_comb begin
    rsp_o.rdata = '0;
    rsp_o.err   = 1'b0;
    case (req_i.offs)
      soc_periph_pkg::REG_EVT_SW: rsp_o.rdata = '0;
      soc_periph_pkg::REG_EVT_STATUS: begin
        if (req_i.rd) begin
          rsp_o.rdata[2:0] = 3'(cnt_q);
          rsp_o.rdata[8]   = ovf_q;
        end
      end
      default: rsp_o.err = 1'b1;
    endcase
  end

  assign fc_event_valid_o = (cnt_q != '0);
  assign fc_event_data_o  = mem_q[rptr_q];

endmodule

`default_nettype wire

//--- hw/ref_timer_unit.sv
/*
 * 32-bit timer, counts system clock cycles or reference clock rising edges
 * registered match pulse on compare, optional clear on match
 */
`timescale 1ns/1ps
`default_nettype none

module ref_timer_unit (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     ref_clk_i,
  input  logic                     stoptimer_i,
  input  soc_periph_pkg::reg_req_t req_i,
  output soc_periph_pkg::reg_rsp_t rsp_o,
  output logic                     tmr_match_o
);

  localparam int unsigned DW = soc_periph_pkg::APB_DATA_WIDTH;

  // two sync stages plus one for edge detect
  logic [2:0]    ref_sync_q;
  logic          ref_rise;
  // cfg[0] enable, cfg[1] ref clock ticks, cfg[2] clear on match
  logic [2:0]    cfg_q;
  logic [DW-1:0] cnt_q;
  logic [DW-1:0] cmp_q;
  logic          tick;
  logic          advance;
  logic          hit;
  logic          match_q;

  ////////////////////
  // ref clock edge
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ref_sync_q <= '0;
    end else begin
      ref_sync_q <= {ref_sync_q[1:0], ref_clk_i};
    end
  end

  assign ref_rise = ref_sync_q[1] & ~ref_sync_q[2];

  // tick source select
  assign tick    = cfg_q[1] ? ref_rise : 1'b1;
  assign advance = cfg_q[0] & ~stoptimer_i & tick;
  // compare only on a counting step, so a stalled counter gives one pulse
  assign hit     = advance & (cnt_q == cmp_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q   <= '0;
      cmp_q   <= '0;
      cnt_q   <= '0;
      match_q <= 1'b0;
    end else begin
      match_q <= hit;
      if (req_i.wr && (req_i.offs == soc_periph_pkg::REG_TMR_CFG)) begin
        cfg_q <= req_i.wdata[2:0];
      end
      if (req_i.wr && (req_i.offs == soc_periph_pkg::REG_TMR_CMP)) begin
        cmp_q <= req_i.wdata;
      end
      // bus write to the counter beats counting
      if (req_i.wr && (req_i.offs == soc_periph_pkg::REG_TMR_CNT)) begin
        cnt_q <= req_i.wdata;
      end else if (hit && cfg_q[2]) begin
        cnt_q <= '0;
      end else if (advance) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  ////////////////////
  // read back
  ////////////////////
  always_comb begin
    rsp_o.rdata = '0;
    rsp_o.err   = 1'b0;
    case (req_i.offs)
      soc_periph_pkg::REG_TMR_CFG: begin
        if (req_i.rd) rsp_o.rdata[2:0] = cfg_q;
      end
      soc_periph_pkg::REG_TMR_CNT: begin
        if (req_i.rd) rsp_o.rdata = cnt_q;
      end
      soc_periph_pkg::REG_TMR_CMP: begin
        if (req_i.rd) rsp_o.rdata = cmp_q;
      end
      default: rsp_o.err = 1'b1;
    endcase
  end

  assign tmr_match_o = match_q;

endmodule

`default_nettype wire

//--- hw/soc_ctrl_regs.sv
/*
 * SoC control registers
 * fabric controller boot address and fetch enable, with external override
 */
`timescale 1ns/1ps
`default_nettype none

module soc_ctrl_regs #(
  parameter logic [31:0] BOOT_ADDR_DEFAULT = 32'h1A00_0080,
  parameter logic [31:0] ROM_BOOT_ADDR     = 32'h1A00_0000
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  soc_periph_pkg::reg_req_t req_i,
  output soc_periph_pkg::reg_rsp_t rsp_o,
  input  logic                     bootsel_i,
  input  logic                     fc_fetch_en_valid_i,
  input  logic                     fc_fetch_en_i,
  output logic [31:0]              fc_bootaddr_o,
  output logic                     fc_fetchen_o
);

  logic [soc_periph_pkg::APB_DATA_WIDTH-1:0] bootaddr_q;
  logic                                      fetchen_q;
  logic                                      wr_boot;
  logic                                      wr_fetch;

  assign wr_boot  = req_i.wr && (req_i.offs == soc_periph_pkg::REG_BOOTADDR);
  assign wr_fetch = req_i.wr && (req_i.offs == soc_periph_pkg::REG_FETCHEN);

  // boot address, comes up at the default entry point
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bootaddr_q <= BOOT_ADDR_DEFAULT;
    end else if (wr_boot) begin
      bootaddr_q <= req_i.wdata;
    end
  end

  // fetch enable
  // external valid wins over a same cycle bus write
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fetchen_q <= 1'b0;
    end else if (fc_fetch_en_valid_i) begin
      fetchen_q <= fc_fetch_en_i;
    end else if (wr_fetch) begin
      fetchen_q <= req_i.wdata[0];
    end
  end

  ////////////////////
  // read back
  ////////////////////
  always_comb begin
    rsp_o.rdata = '0;
    rsp_o.err   = 1'b0;
    case (req_i.offs)
      soc_periph_pkg::REG_BOOTADDR: begin
        if (req_i.rd) rsp_o.rdata = bootaddr_q;
      end
      soc_periph_pkg::REG_FETCHEN: begin
        if (req_i.rd) rsp_o.rdata[0] = fetchen_q;
      end
      default: rsp_o.err = 1'b1;
    endcase
  end

  // rom boot strap overrides the programmed address
  assign fc_bootaddr_o = bootsel_i ? ROM_BOOT_ADDR : bootaddr_q;
  assign fc_fetchen_o  = fetchen_q;

endmodule

`default_nettype wire

//--- hw/periph_apb_decode.sv
/*
 * APB slave front end of the peripheral subsystem
 * tracks setup / access phases, selects one peripheral and muxes its response
 */
`timescale 1ns/1ps
`default_nettype none

module periph_apb_decode (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  soc_periph_pkg::apb_req_t apb_req_i,
  output soc_periph_pkg::apb_rsp_t apb_rsp_o,
  output soc_periph_pkg::reg_req_t ctrl_req_o,
  output soc_periph_pkg::reg_req_t tmr_req_o,
  output soc_periph_pkg::reg_req_t evt_req_o,
  input  soc_periph_pkg::reg_rsp_t ctrl_rsp_i,
  input  soc_periph_pkg::reg_rsp_t tmr_rsp_i,
  input  soc_periph_pkg::reg_rsp_t evt_rsp_i
);

  soc_periph_pkg::apb_state_e  state_q;
  soc_periph_pkg::periph_sel_e sel;
  soc_periph_pkg::reg_rsp_t    sel_rsp;
  logic                        access;

  // one strobe per access, offset and data shared by all windows
  function automatic soc_periph_pkg::reg_req_t build_req(
    input logic                     hit,
    input soc_periph_pkg::apb_req_t req
  );
    soc_periph_pkg::reg_req_t r;
    r.wr    = hit & req.pwrite;
    r.rd    = hit & ~req.pwrite;
    r.offs  = req.paddr[soc_periph_pkg::REG_OFFS_WIDTH-1:0];
    r.wdata = req.pwdata;
    return r;
  endfunction

  ////////////////////
  // phase tracking
  ////////////////////
  // setup seen -> next cycle is the access phase
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= soc_periph_pkg::APB_IDLE;
    end else if (apb_req_i.psel && !apb_req_i.penable) begin
      state_q <= soc_periph_pkg::APB_ACCESS;
    end else begin
      state_q <= soc_periph_pkg::APB_IDLE;
    end
  end

  assign access = (state_q == soc_periph_pkg::APB_ACCESS) &&
                  apb_req_i.psel && apb_req_i.penable;

  // window select from paddr[9:8]
  assign sel = soc_periph_pkg::periph_sel_e'(apb_req_i.paddr[9:8]);

  assign ctrl_req_o = build_req(access && (sel == soc_periph_pkg::SEL_SOC_CTRL), apb_req_i);
  assign tmr_req_o  = build_req(access && (sel == soc_periph_pkg::SEL_TIMER), apb_req_i);
  assign evt_req_o  = build_req(access && (sel == soc_periph_pkg::SEL_EVENT), apb_req_i);

  ////////////////////
  // response mux
  ////////////////////
  always_comb begin
    case (sel)
      soc_periph_pkg::SEL_SOC_CTRL: sel_rsp = ctrl_rsp_i;
      soc_periph_pkg::SEL_TIMER:    sel_rsp = tmr_rsp_i;
      soc_periph_pkg::SEL_EVENT:    sel_rsp = evt_rsp_i;
      default: begin
        // hole in the map, zero data and error
        sel_rsp.rdata = '0;
        sel_rsp.err   = 1'b1;
      end
    endcase
  end

  // no wait states
  assign apb_rsp_o.prdata  = sel_rsp.rdata;
  assign apb_rsp_o.pready  = access;
  assign apb_rsp_o.pslverr = access & sel_rsp.err;

endmodule

`default_nettype wire

//--- hw/soc_periph_pkg.sv
/*
 * soc peripheral subsystem shared types
 * bus widths, address map, register offsets and the APB / register structs
 */
`default_nettype none

package soc_periph_pkg;

  ////////////////////
  // widths
  ////////////////////
  localparam int unsigned APB_ADDR_WIDTH = 32;
  localparam int unsigned APB_DATA_WIDTH = 32;
  // byte offset inside one 256 byte peripheral window
  localparam int unsigned REG_OFFS_WIDTH = 8;
  localparam int unsigned EVNT_WIDTH     = 8;

  // id pushed by the event generator on a timer match
  localparam logic [EVNT_WIDTH-1:0] TIMER_EVENT_ID = 8'd7;

  // peripheral window, taken from paddr[9:8]
  typedef enum logic [1:0] {
    SEL_SOC_CTRL = 2'd0,
    SEL_TIMER    = 2'd1,
    SEL_EVENT    = 2'd2,
    SEL_NONE     = 2'd3
  } periph_sel_e;

  typedef enum logic {
    APB_IDLE   = 1'b0,
    APB_ACCESS = 1'b1
  } apb_state_e;

  ////////////////////
  // register offsets
  ////////////////////
  typedef enum logic [REG_OFFS_WIDTH-1:0] {
    REG_BOOTADDR = 8'h00,
    REG_FETCHEN  = 8'h04
  } soc_ctrl_reg_e;

  typedef enum logic [REG_OFFS_WIDTH-1:0] {
    REG_TMR_CFG = 8'h00,
    REG_TMR_CNT = 8'h04,
    REG_TMR_CMP = 8'h08
  } timer_reg_e;

  typedef enum logic [REG_OFFS_WIDTH-1:0] {
    REG_EVT_SW     = 8'h00,
    REG_EVT_STATUS = 8'h04
  } event_reg_e;

  typedef struct packed {
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
    logic                      pwrite;
    logic                      psel;
    logic                      penable;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
  } apb_rsp_t;

  // single cycle register access toward one peripheral
  typedef struct packed {
    logic                      wr;
    logic                      rd;
    logic [REG_OFFS_WIDTH-1:0] offs;
    logic [APB_DATA_WIDTH-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [APB_DATA_WIDTH-1:0] rdata;
    logic                      err;
  } reg_rsp_t;

endpackage

`default_nettype wire
